// ==== Makefile ====
TOP = tb_mem_pipe

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== ex1_stage.sv ====
`timescale 1ns/1ps

module ex1_stage
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  logic        wb_allowin,

    stage_if.dst        ex_if,

    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_pc,
    output logic [31:0] wb_data,
    output logic        excp_valid,
    output excp_code_t  excp_code,
    output logic [31:0] excp_badv
);

    buf_entry_t  entry;
    logic [63:0] product;
    logic [31:0] result_sel;
    logic        fire;
    logic        has_excp;
    logic        writes_back;

    assign ex_if.allowin = wb_allowin;
    assign entry         = ex_if.entry;

    // shifted partial products give the full unsigned 64-bit product
    assign product = {entry.parts.hh, 32'h0}
                   + {16'h0, entry.parts.hl, 16'h0}
                   + {16'h0, entry.parts.lh, 16'h0}
                   + {32'h0, entry.parts.ll};

    always_comb begin
        case (entry.op)
            op_mul_lo: result_sel = product[31:0];
            op_mul_hi: result_sel = product[63:32];
            default:   result_sel = entry.result;
        endcase
    end

    assign fire        = ex_if.valid && wb_allowin;
    assign has_excp    = (entry.excp != EXCP_NONE);
    // loads and stores retire without writeback
    assign writes_back = !has_excp && !is_mem_op(entry.op);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wb_valid   <= 1'b0;
            excp_valid <= 1'b0;
        end else begin
            wb_valid   <= fire && writes_back;
            excp_valid <= fire && has_excp;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && writes_back) begin
            wb_rd   <= entry.rd;
            wb_pc   <= entry.pc;
            wb_data <= result_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && has_excp) begin
            excp_code <= entry.excp;
            excp_badv <= entry.badv;
        end
    end

endmodule

// ==== mem_pipe_assertions.sv ====
`timescale 1ns/1ps

module mem_pipe_assertions
    import pipe_pkg::*;
(
    input logic       clk,
    input logic       aresetn,
    input logic       flush_by_exception,
    input logic       wb_allowin,
    input logic       issue_allowin,
    input logic       excp_pending,
    input logic       entry_valid,
    input buf_entry_t entry
);

    logic held_excp;

    assign held_excp = entry_valid && (entry.excp != EXCP_NONE);

    // a held exception sets the pending flag, which keeps the producer out
    assert property (@(posedge clk) disable iff (!aresetn)
        ((held_excp || excp_pending) && !flush_by_exception)
            |=> (excp_pending && !issue_allowin))
        else $error("exception pending flag dropped or issue_allowin high before exception flush");

    assert property (@(posedge clk) disable iff (!aresetn)
        flush_by_exception |=> !entry_valid)
        else $error("buffer entry still valid after exception flush");

    // back-pressure freezes a held entry
    assert property (@(posedge clk) disable iff (!aresetn)
        (entry_valid && !wb_allowin && !flush_by_exception) |=> (entry_valid && $stable(entry)))
        else $error("held entry changed while wb_allowin was low");

endmodule

bind mem_stage_buf mem_pipe_assertions u_assertions (
    .clk                (clk),
    .aresetn            (aresetn),
    .flush_by_exception (flush_by_exception),
    .wb_allowin         (wb_allowin),
    .issue_allowin      (req_if.allowin),
    .excp_pending       (excp_pending),
    .entry_valid        (entry_valid),
    .entry              (entry)
);

// ==== mem_pipe_top.sv ====
`timescale 1ns/1ps

module mem_pipe_top
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  logic        flush,
    input  logic        flush_by_exception,
    input  logic        privilege_ready,
    input  logic        wb_allowin,

    input  logic        issue_valid,
    input  logic        is_priv,
    input  mem_op_e     op,
    input  mem_size_e   size,
    input  logic [31:0] pc,
    input  logic [4:0]  rd,
    input  logic [31:0] rj_data,
    input  logic [31:0] rk_data,
    input  logic [31:0] imm,
    input  excp_code_t  in_excp,
    output logic        issue_allowin,

    output logic        dcache_req,
    output logic        dcache_op,
    output logic [3:0]  dcache_wmask,
    output logic [31:0] dcache_addr,
    output logic [31:0] dcache_wdata,

    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_pc,
    output logic [31:0] wb_data,
    output logic        excp_valid,
    output excp_code_t  excp_code,
    output logic [31:0] excp_badv
);

    stage_if req_if ();
    stage_if ex_if ();

    assign issue_allowin = req_if.allowin;

    mem_req_stage u_req (
        .issue_valid  (issue_valid),
        .is_priv      (is_priv),
        .op           (op),
        .size         (size),
        .pc           (pc),
        .rd           (rd),
        .rj_data      (rj_data),
        .rk_data      (rk_data),
        .imm          (imm),
        .in_excp      (in_excp),
        .dcache_req   (dcache_req),
        .dcache_op    (dcache_op),
        .dcache_wmask (dcache_wmask),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .req_if       (req_if.src)
    );

    mem_stage_buf u_buf (
        .clk                (clk),
        .aresetn            (aresetn),
        .flush              (flush),
        .flush_by_exception (flush_by_exception),
        .privilege_ready    (privilege_ready),
        .req_if             (req_if.dst),
        .ex_if              (ex_if.src)
    );

    ex1_stage u_ex1 (
        .clk        (clk),
        .aresetn    (aresetn),
        .wb_allowin (wb_allowin),
        .ex_if      (ex_if.dst),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_pc      (wb_pc),
        .wb_data    (wb_data),
        .excp_valid (excp_valid),
        .excp_code  (excp_code),
        .excp_badv  (excp_badv)
    );

endmodule

// ==== mem_req_stage.sv ====
`timescale 1ns/1ps

module mem_req_stage
    import pipe_pkg::*;
(
    input  logic        issue_valid,
    input  logic        is_priv,
    input  mem_op_e     op,
    input  mem_size_e   size,
    input  logic [31:0] pc,
    input  logic [4:0]  rd,
    input  logic [31:0] rj_data,
    input  logic [31:0] rk_data,
    input  logic [31:0] imm,
    input  excp_code_t  in_excp,

    output logic        dcache_req,
    output logic        dcache_op,
    output logic [3:0]  dcache_wmask,
    output logic [31:0] dcache_addr,
    output logic [31:0] dcache_wdata,

    stage_if.src        req_if
);

    logic [31:0] addr;
    logic        mem_access;
    logic        misaligned;
    excp_code_t  excp;
    mul_parts_t  parts;
    buf_entry_t  entry;

    // the ALU sum doubles as the effective address
    assign addr       = rj_data + imm;
    assign mem_access = is_mem_op(op);
    assign misaligned = mem_access && is_misaligned(size, addr[1:0]);

    // upstream exception wins over alignment check
    always_comb begin
        if (in_excp != EXCP_NONE) begin
            excp = in_excp;
        end else if (misaligned) begin
            excp = EXCP_ALE;
        end else begin
            excp = EXCP_NONE;
        end
    end

    // unsigned 16x16 products of the operand halves
    always_comb begin
        parts.hh = rj_data[31:16] * rk_data[31:16];
        parts.hl = rj_data[31:16] * rk_data[15:0];
        parts.lh = rj_data[15:0] * rk_data[31:16];
        parts.ll = rj_data[15:0] * rk_data[15:0];
    end

    always_comb begin
        entry.pc      = pc;
        entry.rd      = rd;
        entry.op      = op;
        entry.result  = addr;
        entry.parts   = parts;
        entry.excp    = excp;
        entry.badv    = mem_access ? addr : pc;
        entry.is_priv = is_priv;
    end

    assign req_if.valid   = issue_valid;
    assign req_if.entry   = entry;
    assign req_if.is_priv = is_priv;

    // only clean loads and stores reach the cache
    assign dcache_req = issue_valid && req_if.allowin && mem_access
                        && (excp == EXCP_NONE);

    assign dcache_op    = (op == op_store);
    assign dcache_wmask = size_wmask(size);
    assign dcache_addr  = addr;
    assign dcache_wdata = rk_data;

endmodule

// ==== mem_stage_buf.sv ====
`timescale 1ns/1ps

module mem_stage_buf
    import pipe_pkg::*;
(
    input  logic  clk,
    input  logic  aresetn,
    input  logic  flush,
    input  logic  flush_by_exception,
    input  logic  privilege_ready,

    stage_if.dst  req_if,
    stage_if.src  ex_if
);

    logic       entry_valid;
    buf_entry_t entry;
    logic       excp_pending;

    logic       wb_allowin;
    logic       held_excp;
    logic       priv_stall;
    logic       accept;
    logic       clear;

    assign wb_allowin = ex_if.allowin;

    // held exception blocks new work, as does one still waiting for its flush
    assign held_excp  = entry_valid && (entry.excp != EXCP_NONE);
    assign priv_stall = req_if.is_priv && !privilege_ready;

    assign req_if.allowin = wb_allowin && !priv_stall && !(held_excp || excp_pending);

    assign accept = req_if.valid && req_if.allowin;

    // plain flush only takes effect when the next stage moves
    assign clear = !aresetn || flush_by_exception || (flush && wb_allowin);

    always_ff @(posedge clk) begin
        if (clear) begin
            entry_valid <= 1'b0;
        end else if (wb_allowin) begin
            entry_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (!clear && wb_allowin && accept) begin
            entry <= req_if.entry;
        end
    end

    // stays set until the exception flush arrives
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            excp_pending <= 1'b0;
        end else if (flush_by_exception) begin
            excp_pending <= 1'b0;
        end else if (held_excp) begin
            excp_pending <= 1'b1;
        end
    end

    assign ex_if.valid   = entry_valid;
    assign ex_if.entry   = entry;
    // privilege is resolved here, nothing downstream needs it
    assign ex_if.is_priv = 1'b0;

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    // operation class of a lane 0 micro-op
    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_mul_lo = 3'd1,
        op_mul_hi = 3'd2,
        op_load   = 3'd3,
        op_store  = 3'd4
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // zero means no exception
    typedef logic [6:0] excp_code_t;

    localparam excp_code_t EXCP_NONE = 7'h00;
    localparam excp_code_t EXCP_ALE  = 7'h09;

    // 16x16 partial products, summed in the next stage
    typedef struct packed {
        logic [31:0] hh;
        logic [31:0] hl;
        logic [31:0] lh;
        logic [31:0] ll;
    } mul_parts_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        mem_op_e     op;
        logic [31:0] result;
        mul_parts_t  parts;
        excp_code_t  excp;
        logic [31:0] badv;
        logic        is_priv;
    } buf_entry_t;

    function automatic logic is_mem_op(input mem_op_e op);
        return (op == op_load) || (op == op_store);
    endfunction

    // mask is not shifted by the low address bits
    function automatic logic [3:0] size_wmask(input mem_size_e size);
        case (size)
            size_byte: return 4'b0001;
            size_half: return 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic logic is_misaligned(input mem_size_e size, input logic [1:0] lsb);
        return ((size == size_half) && lsb[0]) || ((size == size_word) && (lsb != 2'b00));
    endfunction

endpackage

// ==== stage_if.sv ====
`timescale 1ns/1ps

// level strobes between adjacent stages, entry moves when valid and allowin are high
interface stage_if
    import pipe_pkg::*;
();

    logic       valid;
    logic       allowin;
    logic       is_priv;
    buf_entry_t entry;

    modport src (
        output valid,
        output entry,
        output is_priv,
        input  allowin
    );

    modport dst (
        input  valid,
        input  entry,
        input  is_priv,
        output allowin
    );

endinterface

// ==== tb.f ====
pipe_pkg.sv
stage_if.sv
mem_req_stage.sv
mem_stage_buf.sv
ex1_stage.sv
mem_pipe_top.sv
tb_clock_gen.sv
mem_pipe_assertions.sv
tb_mem_pipe.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic aresetn
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;
    end

endmodule

// ==== tb_mem_pipe.sv ====
`timescale 1ns/1ps

module tb_mem_pipe
    import pipe_pkg::*;
();

    localparam int NUM_CYCLES     = 2000;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 2 * NUM_CYCLES;

    logic clk, aresetn, flush, flush_by_exception, privilege_ready, wb_allowin;
    logic issue_valid, is_priv, issue_allowin;
    mem_op_e op;
    mem_size_e size;
    logic [31:0] pc, rj_data, rk_data, imm;
    logic [4:0] rd;
    excp_code_t in_excp;
    logic dcache_req, dcache_op;
    logic [3:0] dcache_wmask;
    logic [31:0] dcache_addr, dcache_wdata;
    logic wb_valid, excp_valid;
    logic [4:0] wb_rd;
    logic [31:0] wb_pc, wb_data, excp_badv;
    excp_code_t excp_code;

    integer seed = 32'hfa446b9d;
    int cycle_idx = 0;
    int cycle_count = 0;

    // one-entry buffer model
    logic m_valid, m_pending;
    logic [31:0] m_pc, m_result, m_badv;
    logic [63:0] m_prod;
    logic [4:0] m_rd;
    mem_op_e m_op;
    excp_code_t m_excp;

    // expected outputs
    logic e_wb_valid, e_excp_valid, e_allowin, e_req;
    logic [4:0] e_wb_rd;
    logic [31:0] e_wb_pc, e_wb_data, e_excp_badv, e_addr;
    logic [3:0] e_mask;
    excp_code_t e_excp_code, n_excp;

    tb_clock_gen u_clk_gen (.clk(clk), .aresetn(aresetn));

    mem_pipe_top uut (
        .clk(clk), .aresetn(aresetn), .flush(flush), .flush_by_exception(flush_by_exception),
        .privilege_ready(privilege_ready), .wb_allowin(wb_allowin),
        .issue_valid(issue_valid), .is_priv(is_priv), .op(op), .size(size), .pc(pc),
        .rd(rd), .rj_data(rj_data), .rk_data(rk_data), .imm(imm), .in_excp(in_excp),
        .issue_allowin(issue_allowin), .dcache_req(dcache_req), .dcache_op(dcache_op),
        .dcache_wmask(dcache_wmask), .dcache_addr(dcache_addr), .dcache_wdata(dcache_wdata),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_pc(wb_pc), .wb_data(wb_data),
        .excp_valid(excp_valid), .excp_code(excp_code), .excp_badv(excp_badv)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at cycle %0d", cycle_idx);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s cycle %0d: expected %b, actual %b",
                                     name, cycle_idx, exp, act));
        end
    endtask

    task automatic check_wb(input logic [4:0] exp_rd, input logic [31:0] exp_pc,
                            input logic [31:0] exp_data);
        if (wb_rd !== exp_rd || wb_pc !== exp_pc || wb_data !== exp_data) begin
            report_failure($sformatf(
                "[FAIL] writeback cycle %0d: expected rd %0d pc %h data %h, actual rd %0d pc %h data %h",
                cycle_idx, exp_rd, exp_pc, exp_data, wb_rd, wb_pc, wb_data));
        end
    endtask

    task automatic check_excp(input excp_code_t exp_code, input logic [31:0] exp_badv);
        if (excp_code !== exp_code || excp_badv !== exp_badv) begin
            report_failure($sformatf(
                "[FAIL] exception cycle %0d: expected code %h badv %h, actual code %h badv %h",
                cycle_idx, exp_code, exp_badv, excp_code, excp_badv));
        end
    endtask

    task automatic check_dcache(input logic exp_op, input logic [3:0] exp_mask,
                                input logic [31:0] exp_addr, input logic [31:0] exp_data);
        if (dcache_op !== exp_op || dcache_wmask !== exp_mask || dcache_addr !== exp_addr
                || dcache_wdata !== exp_data) begin
            report_failure($sformatf(
                "[FAIL] dcache cycle %0d: expected %b %b %h %h, actual %b %b %h %h", cycle_idx,
                exp_op, exp_mask, exp_addr, exp_data,
                dcache_op, dcache_wmask, dcache_addr, dcache_wdata));
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = $random(seed);
        issue_valid        = (r[1:0] != 2'b00);
        wb_allowin         = (r[3:2] != 2'b00);
        privilege_ready    = (r[5:4] != 2'b00);
        is_priv            = (r[8:6] == 3'b000);
        flush              = (r[12:9] == 4'h0);
        flush_by_exception = (r[16:13] == 4'h0);
        case (r[19:17])
            3'd0, 3'd5: op = op_alu;
            3'd1:       op = op_mul_lo;
            3'd2:       op = op_mul_hi;
            3'd3, 3'd6: op = op_load;
            default:    op = op_store;
        endcase
        case (r[21:20])
            2'd0:    size = size_byte;
            2'd1:    size = size_half;
            default: size = size_word;
        endcase
        in_excp = (r[25:22] == 4'h0) ? {4'h1, r[28:26]} : 7'h00;
        pc      = {$random(seed)} & 32'hffff_fffc;
        rd      = $random(seed);
        rj_data = $random(seed);
        rk_data = $random(seed);
        imm     = $random(seed);
        // keep about half of the addresses aligned
        if (r[29]) begin
            rj_data[1:0] = 2'b00;
            imm[1:0]     = 2'b00;
        end
    endtask

    task automatic predict_comb();
        logic mem_access;
        logic misaligned;
        e_allowin  = wb_allowin && !(is_priv && !privilege_ready)
                     && !(m_valid && m_excp != 7'h00) && !m_pending;
        e_addr     = rj_data + imm;
        mem_access = (op == op_load) || (op == op_store);
        case (size)
            size_byte: e_mask = 4'b0001;
            size_half: e_mask = 4'b0011;
            default:   e_mask = 4'b1111;
        endcase
        misaligned = mem_access && ((size == size_half && e_addr[0])
                     || (size == size_word && e_addr[1:0] != 2'b00));
        if (in_excp != 7'h00) begin
            n_excp = in_excp;
        end else begin
            n_excp = misaligned ? EXCP_ALE : 7'h00;
        end
        e_req = issue_valid && e_allowin && mem_access && (n_excp == 7'h00);
    endtask

    // what the next rising edge does to the model
    task automatic advance_model();
        logic fire;
        logic accept;
        fire         = m_valid && wb_allowin;
        e_wb_valid   = fire && m_excp == 7'h00 && m_op != op_load && m_op != op_store;
        e_excp_valid = fire && m_excp != 7'h00;
        e_wb_rd      = m_rd;
        e_wb_pc      = m_pc;
        case (m_op)
            op_mul_lo: e_wb_data = m_prod[31:0];
            op_mul_hi: e_wb_data = m_prod[63:32];
            default:   e_wb_data = m_result;
        endcase
        e_excp_code = m_excp;
        e_excp_badv = m_badv;
        if (flush_by_exception) begin
            m_pending = 1'b0;
        end else if (m_valid && m_excp != 7'h00) begin
            m_pending = 1'b1;
        end
        accept = issue_valid && e_allowin;
        if (flush_by_exception || (flush && wb_allowin)) begin
            m_valid = 1'b0;
        end else if (wb_allowin) begin
            m_valid = accept;
            if (accept) begin
                m_pc     = pc;
                m_rd     = rd;
                m_op     = op;
                m_result = e_addr;
                m_prod   = {32'h0, rj_data} * {32'h0, rk_data};
                m_excp   = n_excp;
                m_badv   = (op == op_load || op == op_store) ? e_addr : pc;
            end
        end
    endtask

    task automatic check_registered();
        check_bit("wb_valid", e_wb_valid, wb_valid);
        check_bit("excp_valid", e_excp_valid, excp_valid);
        if (e_wb_valid) begin
            check_wb(e_wb_rd, e_wb_pc, e_wb_data);
        end
        if (e_excp_valid) begin
            check_excp(e_excp_code, e_excp_badv);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_failure("timeout: the run went past its cycle limit");
        end
    end

    initial begin
        {flush, flush_by_exception, issue_valid, is_priv} = 4'b0000;
        {privilege_ready, wb_allowin} = 2'b11;
        op = op_alu;
        size = size_word;
        {pc, rj_data, rk_data, imm} = 128'h0;
        rd = 5'd0;
        in_excp = 7'h00;
        {m_valid, m_pending, e_wb_valid, e_excp_valid} = 4'b0000;
        m_excp = 7'h00;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_bit("wb_valid in reset", 1'b0, wb_valid);
            check_bit("excp_valid in reset", 1'b0, excp_valid);
            check_bit("dcache_req in reset", 1'b0, dcache_req);
        end
        wait (aresetn === 1'b1);

        for (cycle_idx = 0; cycle_idx < NUM_CYCLES; cycle_idx++) begin
            @(negedge clk);
            check_registered();
            drive_inputs();
            #1;
            predict_comb();
            check_bit("issue_allowin", e_allowin, issue_allowin);
            check_bit("dcache_req", e_req, dcache_req);
            check_dcache(op == op_store, e_mask, e_addr, rk_data);
            advance_model();
        end
        @(negedge clk);
        check_registered();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
